// File: lfb_geom_pkg.sv
// ############################
// line geometry, fixed at compile time.
// LINE_WORDS must be a power of two so the
// word index wraps on its own.
// ############################

package lfb_geom_pkg;

	// width of one data word.
	parameter int WORD_W = 32;

	// words per line.
	parameter int LINE_WORDS = 8;

	// bits needed to address a word in a line.
	parameter int IDX_W = $clog2(LINE_WORDS);

	// one data word.
	typedef logic [WORD_W-1:0] word_t;

	// position of a word in its line.
	typedef logic [IDX_W-1:0] word_idx_t;

	// per-word valid bits of one slot.
	typedef logic [LINE_WORDS-1:0] word_mask_t;

endpackage

// File: lfb_msg_pkg.sv
// ############################
// beat and line payloads.
// sizes follow the geometry package,
// 35 and 256 bits at the default geometry.
// ############################

package lfb_msg_pkg;

	import lfb_geom_pkg::*;

	// one incoming word and where it lands.
	// word sits in the upper bits, index in the low bits.
	typedef struct packed {
		word_t     word;
		word_idx_t idx;
	} beat_t;

	// a complete line.
	// word 0 is in the low bits.
	typedef struct packed {
		word_t [LINE_WORDS-1:0] words;
	} line_t;

endpackage

// File: fill_steer.sv
// ############################
// strobes while fill_blocked is high are dropped.
// slots are filled strictly in order 0..SLOTS-1.
// ############################

`timescale 1ns/1ns

module fill_steer
	import lfb_geom_pkg::*, lfb_msg_pkg::*;
#(
	parameter int SLOTS = 4
)
(
	input  logic             CLK,
	input  logic             reset,
	input  logic             flush,
	input  logic             beat_strobe,
	input  word_t            beat_word,
	input  logic [SLOTS-1:0] slot_empty,
	output beat_t            beat,
	output logic [SLOTS-1:0] slot_push,
	output logic             fill_blocked
);

	// slot number width, at least one bit.
	localparam int PTR_W = $clog2(SLOTS);

	typedef logic [PTR_W-1:0] slot_idx_t;

	typedef enum logic {
		FS_WAIT_SLOT,
		FS_FILL
	} fill_state_t;

	fill_state_t state;
	slot_idx_t   fill_ptr;
	word_idx_t   word_idx;
	logic        accept;
	logic        last_word;

	// a strobe only counts while a slot is open.
	assign accept = beat_strobe && (state == FS_FILL);
	assign last_word = (word_idx == word_idx_t'(LINE_WORDS - 1));

	// beat carries the running index alongside the word.
	assign beat.word = beat_word;
	assign beat.idx = word_idx;

	// one-hot push toward the slot being filled.
	always_comb begin
		slot_push = '0;
		if (accept) begin
			slot_push[fill_ptr] = 1'b1;
		end
	end

	// source must hold off while no slot is open.
	assign fill_blocked = (state == FS_WAIT_SLOT);

	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			state <= FS_WAIT_SLOT;
			fill_ptr <= '0;
			word_idx <= '0;
		end else begin
			case (state)
				FS_WAIT_SLOT: begin
					// wait for the drain to free the next slot.
					if (slot_empty[fill_ptr]) begin
						state <= FS_FILL;
					end
				end
				FS_FILL: begin
					if (accept) begin
						// index wraps to 0 after the last word.
						word_idx <= word_idx + 1'b1;
						if (last_word) begin
							// line done, move to the next slot.
							if (fill_ptr == slot_idx_t'(SLOTS - 1)) begin
								fill_ptr <= '0;
							end else begin
								fill_ptr <= fill_ptr + 1'b1;
							end
							state <= FS_WAIT_SLOT;
						end
					end
				end
				default: begin
					state <= FS_WAIT_SLOT;
				end
			endcase
		end
	end

endmodule

// File: line_slot.sv
// ############################
// one line of word registers.
// data is kept after a pop; only the valid
// bits say whether a word is present.
// ############################

`timescale 1ns/1ns

module line_slot
	import lfb_geom_pkg::*, lfb_msg_pkg::*;
(
	input  logic  CLK,
	input  logic  reset,
	input  logic  flush,
	input  logic  push,
	input  logic  pop,
	input  beat_t beat,
	output line_t line,
	output logic  full,
	output logic  empty
);

	// word storage, one register per index.
	word_t      words [LINE_WORDS];
	word_mask_t valid;
	word_mask_t word_en;

	generate
		for (genvar w = 0; w < LINE_WORDS; w++) begin : g_word
			// write enable for this index only.
			assign word_en[w] = push && (beat.idx == word_idx_t'(w));

			always_ff @(posedge CLK) begin
				if (word_en[w]) begin
					words[w] <= beat.word;
				end
			end

			// word 0 ends up in the low bits of the line.
			assign line.words[w] = words[w];
		end
	endgenerate

	// valid bits.
	// pop and flush win over a push in the same cycle.
	always_ff @(posedge CLK) begin
		if (reset || flush || pop) begin
			valid <= '0;
		end else if (push) begin
			valid <= valid | word_en;
		end
	end

	// levels straight from the valid bits.
	assign full = &valid;
	assign empty = ~|valid;

endmodule

// File: line_drain.sv
// ############################
// drains slots in order 0..SLOTS-1.
// line_out holds between line_valid pulses.
// ############################

`timescale 1ns/1ns

module line_drain
	import lfb_msg_pkg::*;
#(
	parameter int SLOTS = 4
)
(
	input  logic             CLK,
	input  logic             reset,
	input  logic             flush,
	input  logic             line_stall,
	input  logic [SLOTS-1:0] slot_full,
	input  line_t            slot_lines [SLOTS],
	output logic [SLOTS-1:0] slot_pop,
	output line_t            line_out,
	output logic             line_valid
);

	// slot number width, at least one bit.
	localparam int PTR_W = $clog2(SLOTS);

	typedef logic [PTR_W-1:0] slot_idx_t;

	slot_idx_t drain_ptr;
	logic      take;

	// oldest slot is complete and the sink takes it.
	assign take = slot_full[drain_ptr] && !line_stall;

	// pop lands on the same edge as the capture.
	always_comb begin
		slot_pop = '0;
		if (take) begin
			slot_pop[drain_ptr] = 1'b1;
		end
	end

	// control side.
	// flush beats a capture in the same cycle.
	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			drain_ptr <= '0;
			line_valid <= 1'b0;
		end else begin
			line_valid <= take;
			if (take) begin
				if (drain_ptr == slot_idx_t'(SLOTS - 1)) begin
					drain_ptr <= '0;
				end else begin
					drain_ptr <= drain_ptr + 1'b1;
				end
			end
		end
	end

	// output line register.
	// only loads on a capture, never under reset or flush.
	always_ff @(posedge CLK) begin
		if (take && !(reset || flush)) begin
			line_out <= slot_lines[drain_ptr];
		end
	end

endmodule

// File: lfb_top.sv
// ############################
// line fill buffer bank, SLOTS >= 2.
// plain strobes, no handshake. source must
// watch fill_blocked, sink uses line_stall.
// ############################

`timescale 1ns/1ns

module lfb_top
	import lfb_geom_pkg::*, lfb_msg_pkg::*;
#(
	parameter int SLOTS = 4
)
(
	input  logic  CLK,
	input  logic  reset,
	input  logic  flush,
	input  logic  beat_strobe,
	input  word_t beat_word,
	input  logic  line_stall,
	output line_t line_out,
	output logic  line_valid,
	output logic  fill_blocked
);

	// beat broadcast to every slot.
	beat_t beat;

	// per-slot strobes and levels.
	logic [SLOTS-1:0] slot_push;
	logic [SLOTS-1:0] slot_pop;
	logic [SLOTS-1:0] slot_full;
	logic [SLOTS-1:0] slot_empty;

	// lines from the slots toward the drain.
	line_t slot_lines [SLOTS];

	// fill side.
	fill_steer #(
		.SLOTS(SLOTS)
	) u_steer (
		.CLK         (CLK),
		.reset       (reset),
		.flush       (flush),
		.beat_strobe (beat_strobe),
		.beat_word   (beat_word),
		.slot_empty  (slot_empty),
		.beat        (beat),
		.slot_push   (slot_push),
		.fill_blocked(fill_blocked)
	);

	// slot array.
	generate
		for (genvar s = 0; s < SLOTS; s++) begin : g_slot
			line_slot u_slot (
				.CLK  (CLK),
				.reset(reset),
				.flush(flush),
				.push (slot_push[s]),
				.pop  (slot_pop[s]),
				.beat (beat),
				.line (slot_lines[s]),
				.full (slot_full[s]),
				.empty(slot_empty[s])
			);
		end
	endgenerate

	// drain side.
	line_drain #(
		.SLOTS(SLOTS)
	) u_drain (
		.CLK       (CLK),
		.reset     (reset),
		.flush     (flush),
		.line_stall(line_stall),
		.slot_full (slot_full),
		.slot_lines(slot_lines),
		.slot_pop  (slot_pop),
		.line_out  (line_out),
		.line_valid(line_valid)
	);

endmodule

// File: tb_lfb.sv
// ############################
// directed testbench for lfb_top at SLOTS = 4.
// inputs change 2 ns after the rising edge.
// outputs are sampled on the falling edge.
// ############################

`timescale 1ns/1ns

module tb_lfb
	import lfb_geom_pkg::*, lfb_msg_pkg::*;
();

	localparam int SLOTS = 4;
	localparam int MAX_CYCLES = 4000;
	localparam int CMP_W = $bits(line_t);

	logic  CLK;
	logic  reset;
	logic  flush;
	logic  beat_strobe;
	word_t beat_word;
	logic  line_stall;
	line_t line_out;
	logic  line_valid;
	logic  fill_blocked;

	// bookkeeping.
	int    errors;
	int    checks;
	int    rx_count;
	int    cycles;
	string cur_test;
	line_t expected [$];
	line_t rx_lines [$];
	line_t exp_line;

	lfb_top #(
		.SLOTS(SLOTS)
	) dut (
		.CLK         (CLK),
		.reset       (reset),
		.flush       (flush),
		.beat_strobe (beat_strobe),
		.beat_word   (beat_word),
		.line_stall  (line_stall),
		.line_out    (line_out),
		.line_valid  (line_valid),
		.fill_blocked(fill_blocked)
	);

	// 40 ns clock.
	always #20 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles <= cycles + 1;
	end

	// run limit, far above the total test length.
	initial begin
		wait (cycles >= MAX_CYCLES);
		$display("timeout: simulation ran for %0d cycles without finishing", cycles);
		$display("sim failed");
		$finish;
	end

	task automatic check_value(input string what, input logic [CMP_W-1:0] exp_val,
		input logic [CMP_W-1:0] act_val);
		checks++;
		if (act_val !== exp_val) begin
			errors++;
			$display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp_val, act_val);
		end
	endtask

	// output monitor, compares each line with the scoreboard.
	always @(negedge CLK) begin
		if (!reset && line_valid === 1'b1) begin
			rx_count++;
			rx_lines.push_back(line_out);
			if (expected.size() == 0) begin
				errors++;
				$display("%s: a line came out that was never expected", cur_test);
			end else begin
				exp_line = expected.pop_front();
				check_value("line_out", exp_line, line_out);
			end
		end
	end

	// one cycle on, inputs change 2 ns after the edge.
	task automatic next_cycle();
		@(posedge CLK);
		#2;
	endtask

	// one strobe, held off while the source is blocked.
	task automatic push_word(input word_t w);
		int waited;
		waited = 0;
		while (fill_blocked && waited < 100) begin
			next_cycle();
			waited++;
		end
		if (fill_blocked) begin
			errors++;
			$display("%s: fill_blocked never fell, word sent anyway", cur_test);
		end
		beat_strobe = 1'b1;
		beat_word = w;
		next_cycle();
		beat_strobe = 1'b0;
	endtask

	// a whole line of random words, index 0 first.
	task automatic send_line(input bit expect_out, output line_t ln);
		word_t w;
		for (int i = 0; i < LINE_WORDS; i++) begin
			w = $urandom;
			ln.words[i] = w;
			push_word(w);
		end
		if (expect_out) begin
			expected.push_back(ln);
		end
	endtask

	task automatic wait_lines(input int target, input int limit);
		int waited;
		waited = 0;
		while (rx_count < target && waited < limit) begin
			next_cycle();
			waited++;
		end
		if (rx_count < target) begin
			errors++;
			$display("%s: only %0d of %0d lines arrived", cur_test, rx_count, target);
		end
	endtask

	task automatic test_single_line();
		line_t ln;
		cur_test = "test_single_line";
		send_line(1'b1, ln);
		// slot full now, capture on the next edge.
		check_value("line_valid early", 1'b0, line_valid);
		next_cycle();
		check_value("line_valid", 1'b1, line_valid);
		check_value("line_out direct", ln, line_out);
		next_cycle();
		check_value("line_valid pulse", 1'b0, line_valid);
		next_cycle();
		check_value("fill_blocked", 1'b0, fill_blocked);
	endtask

	task automatic test_stream_order();
		line_t ln;
		int start;
		cur_test = "test_stream_order";
		start = rx_count;
		for (int i = 0; i < 6; i++) begin
			send_line(1'b1, ln);
		end
		wait_lines(start + 6, 40);
		repeat (4) next_cycle();
		check_value("line count", 6, rx_count - start);
		check_value("scoreboard left", 0, expected.size());
	endtask

	task automatic test_backpressure();
		line_t ln;
		int start;
		cur_test = "test_backpressure";
		start = rx_count;
		line_stall = 1'b1;
		for (int i = 0; i < SLOTS; i++) begin
			send_line(1'b1, ln);
		end
		next_cycle();
		check_value("fill_blocked full", 1'b1, fill_blocked);
		repeat (4) next_cycle();
		check_value("lines under stall", 0, rx_count - start);
		line_stall = 1'b0;
		wait_lines(start + SLOTS, 40);
		next_cycle();
		check_value("fill_blocked drained", 1'b0, fill_blocked);
		check_value("scoreboard left", 0, expected.size());
	endtask

	task automatic test_blocked_drop();
		line_t ln;
		word_t dropped [$];
		word_t w;
		int start;
		cur_test = "test_blocked_drop";
		start = rx_count;
		line_stall = 1'b1;
		for (int i = 0; i < SLOTS; i++) begin
			send_line(1'b1, ln);
		end
		// strobes against a full bank are lost.
		for (int i = 0; i < LINE_WORDS; i++) begin
			check_value("fill_blocked held", 1'b1, fill_blocked);
			w = $urandom;
			dropped.push_back(w);
			beat_strobe = 1'b1;
			beat_word = w;
			next_cycle();
		end
		beat_strobe = 1'b0;
		line_stall = 1'b0;
		send_line(1'b1, ln);
		wait_lines(start + SLOTS + 1, 60);
		repeat (4) next_cycle();
		check_value("line count", SLOTS + 1, rx_count - start);
		for (int i = start; i < rx_lines.size(); i++) begin
			for (int j = 0; j < LINE_WORDS; j++) begin
				foreach (dropped[k]) begin
					if (rx_lines[i].words[j] === dropped[k]) begin
						errors++;
						$display("%s: a dropped word showed up in output line %0d",
							cur_test, i);
					end
				end
			end
		end
	endtask

	task automatic test_flush();
		line_t ln;
		int start;
		cur_test = "test_flush";
		start = rx_count;
		line_stall = 1'b1;
		send_line(1'b0, ln);
		// half a line left in the next slot.
		for (int i = 0; i < LINE_WORDS / 2; i++) begin
			push_word($urandom);
		end
		flush = 1'b1;
		next_cycle();
		flush = 1'b0;
		line_stall = 1'b0;
		repeat (6) next_cycle();
		check_value("lines after flush", 0, rx_count - start);
		check_value("fill_blocked", 1'b0, fill_blocked);
		// index must restart at 0 for this line.
		send_line(1'b1, ln);
		wait_lines(start + 1, 20);
		repeat (4) next_cycle();
		check_value("scoreboard left", 0, expected.size());
	endtask

	initial begin
		CLK = 1'b0;
		reset = 1'b1;
		flush = 1'b0;
		beat_strobe = 1'b0;
		beat_word = '0;
		line_stall = 1'b0;
		errors = 0;
		checks = 0;
		rx_count = 0;
		cycles = 0;
		cur_test = "reset";
		void'($urandom(31917));
		repeat (16) @(posedge CLK);
		#2;
		reset = 1'b0;
		check_value("fill_blocked after reset", 1'b1, fill_blocked);
		next_cycle();
		test_single_line();
		test_stream_order();
		test_backpressure();
		test_blocked_drop();
		test_flush();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: list.f
lfb_geom_pkg.sv
lfb_msg_pkg.sv
fill_steer.sv
line_slot.sv
line_drain.sv
lfb_top.sv
tb_lfb.sv

// File: Bender.yml
package:
  name: lfb

dependencies: {}

sources:
  # packages first, the RTL imports them.
  - lfb_geom_pkg.sv
  - lfb_msg_pkg.sv
  # RTL, leaf modules before the top level.
  - fill_steer.sv
  - line_slot.sv
  - line_drain.sv
  - lfb_top.sv
  # testbench.
  - target: simulation
    files:
      - tb_lfb.sv
